//--- tinyCore.f
rtl/CorePkg.sv
rtl/CoreIF.sv
rtl/MemoryAccessController.sv
rtl/FetchStage.sv
rtl/ExecuteStage.sv
rtl/MemoryStage.sv
rtl/Core.sv
tests/MemoryModel.sv
tests/CoreTb.sv

//--- Bender.yml
package:
  name: tinyCore

sources:
  - rtl/CorePkg.sv
  - rtl/CoreIF.sv
  - rtl/MemoryAccessController.sv
  - rtl/FetchStage.sv
  - rtl/ExecuteStage.sv
  - rtl/MemoryStage.sv
  - rtl/Core.sv
  - target: test
    files:
      - tests/MemoryModel.sv
      - tests/CoreTb.sv

//--- tests/CoreTb.sv
// Core testbench
// Program builders, ISA reference model, result comparison,
// the test sequence and a cycle budget watchdog

module CoreTb;
    timeunit 1ns;
    timeprecision 1ps;
    import CorePkg::*;

    localparam AddrPath ResetPc    = 16'h0000;
    localparam AddrPath SerialAddr = 16'hFF00;

    typedef logic [7:0] ByteQueue [$];
    typedef DataPath WordQueue [$];

    logic       clk = 1'b0;
    logic       reset = 1'b1;
    MemSerial   nextMemReadSerial;
    MemSerial   memReadSerial;
    DataPath    memReadData;
    logic       memReadDataReady;
    logic       memAccessReadBusy;
    logic       memAccessWriteBusy;
    AddrPath    memAccessAddr;
    DataPath    memAccessWriteData;
    logic       memAccessRE;
    logic       memAccessWE;
    logic       serialWE;
    logic [7:0] serialWriteData;
    AddrPath    lastCommittedPC;
    logic       halted;

    DataPath  image [AddrPath];
    DataPath  aluImage [AddrPath];
    DataPath  memImage [AddrPath];
    DataPath  loopImage [AddrPath];
    AddrPath  progLen;
    ByteQueue expSerial;
    ByteQueue gotSerial;
    WordQueue expWAddr;
    WordQueue expWData;
    AddrPath  expHalt;
    int       errorCount = 0;
    int       testCount = 0;
    int       failedTests = 0;
    longint   budget = 64;
    longint   cycleCount = 0;
    bit       checked = 1'b0;

    always #10 clk = ~clk;

    Core #(.ResetPc(ResetPc), .SerialAddr(SerialAddr)) dut_i (.*);

    MemoryModel mem_i (.*);

    task automatic reportMismatch(input string msg);
        errorCount++;
        $display("FAIL %0t ns: %s", $time, msg);
    endtask

    function automatic DataPath immInsn(logic [3:0] op, RegNum rd, RegNum rs1, logic [7:0] imm);
        return {op, rd, rs1, imm};
    endfunction

    function automatic DataPath regInsn(logic [3:0] op, RegNum rd, RegNum rs1, RegNum rs2);
        return {op, rd, rs1, rs2, 6'b0};
    endfunction

    // r3 holds 16'hFF80, so offset -128 lands on the serial port
    function automatic DataPath serialStore(RegNum src);
        return immInsn(4'd6, src, 2'd3, 8'h80);
    endfunction

    function automatic logic [7:0] randomByte();
        return 8'($urandom);
    endfunction

    task automatic newProgram();
        image.delete();
        progLen = ResetPc;
    endtask

    task automatic emit(input DataPath word);
        image[progLen] = word;
        progLen++;
    endtask

    task automatic straightLineProgram(input int n);
        logic [3:0] op;
        RegNum      rd;
        newProgram();
        for (int i = 0; i < 3; i++) emit(immInsn(4'd0, RegNum'(i), 2'd0, randomByte()));
        emit(immInsn(4'd0, 2'd3, 2'd0, 8'h00));
        emit(immInsn(4'd1, 2'd3, 2'd3, 8'h80));
        repeat (n) begin
            op = 4'($urandom_range(4));
            rd = RegNum'($urandom_range(2));
            if (op <= 4'd1) emit(immInsn(op, rd, RegNum'($urandom_range(3)), randomByte()));
            else emit(regInsn(op, rd, RegNum'($urandom_range(3)), RegNum'($urandom_range(3))));
            emit(serialStore(rd));
        end
        for (int i = 0; i < 4; i++) emit(serialStore(RegNum'(i)));
        emit(immInsn(4'd15, 2'd0, 2'd0, 8'h00));
    endtask

    // Data area at 16'h0030..16'h0051, clear of the code
    task automatic loadStoreProgram();
        newProgram();
        image[16'h0050] = DataPath'($urandom);
        image[16'h0051] = DataPath'($urandom);
        emit(immInsn(4'd0, 2'd3, 2'd0, 8'h40));
        for (int i = 0; i < 3; i++) begin
            emit(immInsn(4'd0, RegNum'(i), 2'd0, randomByte()));
            emit(immInsn(4'd6, RegNum'(i), 2'd3, 8'(i)));
        end
        emit(immInsn(4'd5, 2'd0, 2'd3, 8'h10));
        emit(immInsn(4'd5, 2'd1, 2'd3, 8'h11));
        emit(regInsn(4'd2, 2'd2, 2'd0, 2'd1));
        emit(immInsn(4'd6, 2'd0, 2'd3, 8'h03));
        emit(immInsn(4'd6, 2'd1, 2'd3, 8'h04));
        emit(immInsn(4'd6, 2'd2, 2'd3, 8'hF0));
        emit(immInsn(4'd5, 2'd0, 2'd3, 8'h01));
        emit(immInsn(4'd6, 2'd0, 2'd3, 8'h05));
        emit(immInsn(4'd5, 2'd1, 2'd3, 8'hF0));
        emit(immInsn(4'd6, 2'd1, 2'd3, 8'h06));
        emit(immInsn(4'd15, 2'd0, 2'd0, 8'h00));
    endtask

    task automatic countdownProgram(input int count);
        AddrPath top;
        newProgram();
        emit(immInsn(4'd0, 2'd3, 2'd0, 8'h00));
        emit(immInsn(4'd1, 2'd3, 2'd3, 8'h80));
        emit(immInsn(4'd0, 2'd1, 2'd0, 8'h00));
        emit(immInsn(4'd0, 2'd0, 2'd0, 8'(count)));
        top = progLen;
        emit(serialStore(2'd0));
        emit(immInsn(4'd1, 2'd0, 2'd0, 8'hFF));
        // Exit when r0 hits zero, else branch back on r1 == 0
        emit(immInsn(4'd7, 2'd0, 2'd0, 8'h01));
        emit(immInsn(4'd7, 2'd0, 2'd1, 8'(top - progLen - 16'd1)));
        emit(immInsn(4'd15, 2'd0, 2'd0, 8'h00));
    endtask

    // ISA reference, straight from the instruction definitions
    function automatic void runProgram(output ByteQueue serialOut, output WordQueue addrOut,
                                       output WordQueue dataOut, output AddrPath haltPc,
                                       output int steps);
        DataPath    m [AddrPath];
        DataPath    r [4];
        AddrPath    pc;
        DataPath    insn;
        logic [3:0] op;
        RegNum      rd;
        RegNum      rs1;
        RegNum      rs2;
        DataPath    immS;
        AddrPath    ea;
        bit         done;
        m = image;
        foreach (r[i]) r[i] = '0;
        pc = ResetPc;
        serialOut = {};
        addrOut = {};
        dataOut = {};
        haltPc = '0;
        steps = 0;
        done = 1'b0;
        while (!done && steps < 5000) begin
            insn = m.exists(pc) ? m[pc] : '0;
            op   = insn[15:12];
            rd   = insn[11:10];
            rs1  = insn[9:8];
            rs2  = insn[7:6];
            immS = {{8{insn[7]}}, insn[7:0]};
            ea   = r[rs1] + immS;
            steps++;
            case (op)
                4'd0: r[rd] = {8'h00, insn[7:0]};
                4'd1: r[rd] = r[rs1] + immS;
                4'd2: r[rd] = r[rs1] + r[rs2];
                4'd3: r[rd] = r[rs1] - r[rs2];
                4'd4: r[rd] = r[rs1] ^ r[rs2];
                4'd5: r[rd] = m.exists(ea) ? m[ea] : '0;
                4'd6: begin
                    if (ea == SerialAddr) begin
                        serialOut.push_back(r[rd][7:0]);
                    end else begin
                        m[ea] = r[rd];
                        addrOut.push_back(ea);
                        dataOut.push_back(r[rd]);
                    end
                end
                4'd7: if (r[rs1] == '0) pc = pc + immS;
                4'd15: begin
                    haltPc = pc;
                    done = 1'b1;
                end
                default: ;
            endcase
            pc = pc + 16'd1;
        end
    endfunction

    task automatic compareResults();
        assert (gotSerial.size() == expSerial.size())
            else reportMismatch($sformatf("%0d serial bytes, expected %0d",
                                          gotSerial.size(), expSerial.size()));
        foreach (expSerial[i]) begin
            if (i < gotSerial.size()) begin
                assert (gotSerial[i] == expSerial[i])
                    else reportMismatch($sformatf("serial byte %0d is %h, expected %h",
                                                  i, gotSerial[i], expSerial[i]));
            end
        end
        assert (mem_i.writeAddrQ.size() == expWAddr.size())
            else reportMismatch($sformatf("%0d memory writes, expected %0d",
                                          mem_i.writeAddrQ.size(), expWAddr.size()));
        foreach (expWAddr[i]) begin
            if (i < mem_i.writeAddrQ.size()) begin
                assert (mem_i.writeAddrQ[i] == expWAddr[i] && mem_i.writeDataQ[i] == expWData[i])
                    else reportMismatch($sformatf("write %0d is %h at %h, expected %h at %h", i,
                                                  mem_i.writeDataQ[i], mem_i.writeAddrQ[i],
                                                  expWData[i], expWAddr[i]));
            end
        end
        assert (lastCommittedPC == expHalt)
            else reportMismatch($sformatf("lastCommittedPC is %h, expected %h",
                                          lastCommittedPC, expHalt));
        assert (mem_i.strobeViolations == 0) else begin
            errorCount++;
            $display("Memory saw %0d read or write strobes while it was busy",
                     mem_i.strobeViolations);
        end
    endtask

    // Collects serial bytes and compares once the core halts
    always @(posedge clk) begin
        if (reset) begin
            gotSerial.delete();
            checked = 1'b0;
        end else if (!checked) begin
            if (serialWE) gotSerial.push_back(serialWriteData);
            if (halted) begin
                compareResults();
                checked = 1'b1;
            end
        end
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount > budget) begin
            $display("Timeout after %0d cycles, the core did not halt", cycleCount);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    task automatic runTest(input string name, input bit startup, input int busy, input bit decoy);
        int steps;
        int errorsBefore;
        runProgram(expSerial, expWAddr, expWData, expHalt, steps);
        // Forty cycles per executed instruction, plus reset
        budget += steps * 40 + 32;
        @(negedge clk);
        reset = 1'b1;
        mem_i.busyPercent = busy;
        mem_i.decoyEn = decoy;
        mem_i.clearMemory();
        foreach (image[a]) mem_i.words[a] = image[a];
        repeat (16) @(negedge clk);
        reset = 1'b0;
        errorsBefore = errorCount;
        if (startup) begin
            do begin
                @(posedge clk);
                assert (!memAccessWE && !serialWE && lastCommittedPC == '0 && !halted)
                    else reportMismatch("core active before its first instruction read");
            end while (!memAccessRE);
            assert (memAccessAddr == ResetPc)
                else reportMismatch($sformatf("first read at %h", memAccessAddr));
        end
        while (!checked) @(posedge clk);
        testCount++;
        if (errorCount == errorsBefore) begin
            $display("test %0d %s: ok", testCount, name);
        end else begin
            failedTests++;
            $display("test %0d %s: %0d errors", testCount, name, errorCount - errorsBefore);
        end
    endtask

    initial begin
        void'($urandom(32'h17b1_2743));
        straightLineProgram(3);
        runTest("reset state and first fetch", 1'b1, 10, 1'b0);
        straightLineProgram(20);
        aluImage = image;
        runTest("ALU program to serial port", 1'b0, 20, 1'b0);
        loadStoreProgram();
        memImage = image;
        runTest("stores and loads", 1'b0, 20, 1'b0);
        countdownProgram($urandom_range(9, 3));
        loopImage = image;
        runTest("countdown loop", 1'b0, 20, 1'b0);
        image = aluImage;
        runTest("ALU program with decoys", 1'b0, 20, 1'b1);
        image = memImage;
        runTest("stores and loads with decoys", 1'b0, 20, 1'b1);
        image = loopImage;
        runTest("countdown loop with decoys", 1'b0, 20, 1'b1);
        image = aluImage;
        runTest("ALU program under heavy busy", 1'b0, 75, 1'b0);
        image = memImage;
        runTest("stores and loads under heavy busy", 1'b0, 75, 1'b0);
        image = loopImage;
        runTest("countdown loop under heavy busy", 1'b0, 75, 1'b0);
        $display("%0d tests, %0d failed, %0d errors", testCount, failedTests, errorCount);
        if (errorCount == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule : CoreTb

//--- tests/MemoryModel.sv
// Behavioral external memory for the core testbench
// Random busy levels, serial-tagged reads with random latency,
// optional decoy responses and a log of accepted writes

module MemoryModel (
    input  logic              clk,
    input  logic              reset,
    input  logic              memAccessRE,
    input  logic              memAccessWE,
    input  CorePkg::AddrPath  memAccessAddr,
    input  CorePkg::DataPath  memAccessWriteData,
    output logic              memAccessReadBusy,
    output logic              memAccessWriteBusy,
    output CorePkg::MemSerial nextMemReadSerial,
    output CorePkg::MemSerial memReadSerial,
    output CorePkg::DataPath  memReadData,
    output logic              memReadDataReady
);
    timeunit 1ns;
    timeprecision 1ps;
    import CorePkg::*;

    DataPath  words [AddrPath];
    AddrPath  writeAddrQ [$];
    DataPath  writeDataQ [$];
    int       busyPercent = 0;
    bit       decoyEn = 1'b0;
    int       strobeViolations = 0;
    MemSerial serialCount = '0;
    bit       pending = 1'b0;
    MemSerial pendingSerial = '0;
    AddrPath  pendingAddr;
    int       delay;
    bit       decoyDue;

    function automatic DataPath readWord(input AddrPath a);
        return words.exists(a) ? words[a] : '0;
    endfunction

    task automatic clearMemory();
        words.delete();
        writeAddrQ.delete();
        writeDataQ.delete();
        strobeViolations = 0;
    endtask

    initial begin
        memAccessReadBusy  = 1'b0;
        memAccessWriteBusy = 1'b0;
        nextMemReadSerial  = '0;
        memReadSerial      = '0;
        memReadData        = '0;
        memReadDataReady   = 1'b0;
    end

    // Requests are taken at the rising edge
    always @(posedge clk) begin
        if (reset) begin
            pending     = 1'b0;
            serialCount = '0;
        end else begin
            if ((memAccessRE && memAccessReadBusy) || (memAccessWE && memAccessWriteBusy))
                strobeViolations++;
            if (memAccessWE && !memAccessWriteBusy) begin
                words[memAccessAddr] = memAccessWriteData;
                writeAddrQ.push_back(memAccessAddr);
                writeDataQ.push_back(memAccessWriteData);
            end
            if (memAccessRE && !memAccessReadBusy) begin
                pending       = 1'b1;
                pendingSerial = serialCount;
                pendingAddr   = memAccessAddr;
                serialCount++;
                delay    = $urandom_range(6, 1);
                decoyDue = decoyEn;
            end
        end
    end

    // Outputs change at the falling edge
    always @(negedge clk) begin
        if (reset) begin
            memAccessReadBusy  <= 1'b0;
            memAccessWriteBusy <= 1'b0;
            nextMemReadSerial  <= '0;
            memReadDataReady   <= 1'b0;
        end else begin
            memAccessReadBusy  <= ($urandom_range(99) < busyPercent);
            memAccessWriteBusy <= ($urandom_range(99) < busyPercent);
            nextMemReadSerial  <= serialCount;
            memReadDataReady   <= 1'b0;
            memReadSerial      <= pendingSerial + 4'd8;
            memReadData        <= DataPath'($urandom);
            if (pending) begin
                if (delay > 1) begin
                    delay--;
                end else if (decoyDue) begin
                    // Wrong serial with garbage data ahead of the real answer
                    memReadDataReady <= 1'b1;
                    memReadSerial    <= pendingSerial + 4'd7;
                    decoyDue = 1'b0;
                    delay    = $urandom_range(3, 1);
                end else begin
                    memReadDataReady <= 1'b1;
                    memReadSerial    <= pendingSerial;
                    memReadData      <= readWord(pendingAddr);
                    pending = 1'b0;
                end
            end
        end
    end

endmodule : MemoryModel

//--- rtl/Core.sv
// Core top level
// Stages and memory access controller joined by interfaces,
// plus the committed PC and halted status registers

module Core #(
    parameter CorePkg::AddrPath ResetPc    = '0,
    parameter CorePkg::AddrPath SerialAddr = 16'hFF00
) (
    input  logic              clk,
    input  logic              reset,
    input  CorePkg::MemSerial nextMemReadSerial,
    input  CorePkg::MemSerial memReadSerial,
    input  CorePkg::DataPath  memReadData,
    input  logic              memReadDataReady,
    input  logic              memAccessReadBusy,
    input  logic              memAccessWriteBusy,
    output CorePkg::AddrPath  memAccessAddr,
    output CorePkg::DataPath  memAccessWriteData,
    output logic              memAccessRE,
    output logic              memAccessWE,
    output logic              serialWE,
    output logic [7:0]        serialWriteData,
    output CorePkg::AddrPath  lastCommittedPC,
    output logic              halted
);
    import CorePkg::*;

    logic       issueValid;
    Instruction issueInsn;
    AddrPath    issuePc;
    logic       retire;
    AddrPath    retirePc;
    AddrPath    retireNextPc;
    logic       retireHalt;

    MemPortIF memPort ();
    ExecMemIF execMem ();

    MemoryAccessController memCtrl_i (
        .clk, .reset, .port(memPort.ctrl),
        .nextMemReadSerial, .memReadSerial, .memReadData, .memReadDataReady,
        .memAccessReadBusy, .memAccessWriteBusy,
        .memAccessAddr, .memAccessWriteData, .memAccessRE, .memAccessWE
    );

    FetchStage #(.ResetPc(ResetPc)) fetch_i (
        .clk, .reset, .mem(memPort.fetch),
        .issueValid, .issueInsn, .issuePc,
        .retire, .retireNextPc, .retireHalt
    );

    ExecuteStage execute_i (
        .clk, .reset, .issueValid, .issueInsn, .issuePc, .em(execMem.exec)
    );

    MemoryStage #(.SerialAddr(SerialAddr)) memStage_i (
        .clk, .reset, .em(execMem.mem), .mem(memPort.data),
        .serialWE, .serialWriteData,
        .retire, .retirePc, .retireNextPc, .retireHalt
    );

    // Commit status, one cycle behind retire
    always_ff @(posedge clk) begin
        if (reset) begin
            lastCommittedPC <= '0;
            halted          <= 1'b0;
        end else if (retire) begin
            lastCommittedPC <= retirePc;
            if (retireHalt) halted <= 1'b1;
        end
    end

endmodule : Core

//--- rtl/MemoryStage.sv
// Memory stage
// Loads and stores through the controller, serial port output,
// register write-back and the retire pulse

module MemoryStage #(
    parameter CorePkg::AddrPath SerialAddr = 16'hFF00
) (
    input  logic             clk,
    input  logic             reset,
    ExecMemIF.mem            em,
    MemPortIF.data           mem,
    output logic             serialWE,
    output logic [7:0]       serialWriteData,
    output logic             retire,
    output CorePkg::AddrPath retirePc,
    output CorePkg::AddrPath retireNextPc,
    output logic             retireHalt
);
    import CorePkg::*;

    logic dataReq;
    logic isSerial;

    assign isSerial = (em.kind == MEM_STORE) && (em.addr == SerialAddr);

    // Request payload comes straight from the held execute bundle
    assign mem.dataReq   = dataReq;
    assign mem.dataWrite = (em.kind == MEM_STORE);
    assign mem.dataAddr  = em.addr;
    assign mem.dataWData = em.storeData;

    always_ff @(posedge clk) begin
        if (reset) begin
            dataReq  <= 1'b0;
            retire   <= 1'b0;
            serialWE <= 1'b0;
            em.wbEn  <= 1'b0;
        end else begin
            retire   <= 1'b0;
            serialWE <= 1'b0;
            em.wbEn  <= 1'b0;
            if (em.valid) begin
                if (em.kind == MEM_NONE || isSerial) begin
                    retire   <= 1'b1;
                    serialWE <= isSerial;
                    em.wbEn  <= em.writeReg;
                end else begin
                    dataReq <= 1'b1;
                end
            end else if (dataReq && mem.dataDone) begin
                dataReq <= 1'b0;
                retire  <= 1'b1;
                em.wbEn <= em.writeReg;
            end
        end
    end

    always_ff @(posedge clk) begin
        em.wbReg        <= em.rd;
        em.wbData       <= (em.kind == MEM_LOAD) ? mem.dataRData : em.result;
        serialWriteData <= em.storeData[7:0];
        retirePc        <= em.pc;
        retireNextPc    <= em.nextPc;
        retireHalt      <= em.halt;
    end

endmodule : MemoryStage

//--- rtl/ExecuteStage.sv
// Execute stage
// Decode of both instruction forms, the register file, ALU,
// effective address and next PC, registered into ExecMemIF

module ExecuteStage (
    input  logic                clk,
    input  logic                reset,
    input  logic                issueValid,
    input  CorePkg::Instruction issueInsn,
    input  CorePkg::AddrPath    issuePc,
    ExecMemIF.exec              em
);
    import CorePkg::*;

    DataPath [3:0] regFile;
    DataPath       rs1Val;
    DataPath       rs2Val;
    DataPath       rdVal;
    DataPath       immSext;
    DataPath       immZext;
    MemKind        kind;
    logic          writeReg;
    logic          halt;
    DataPath       result;
    AddrPath       nextPc;

    always_comb begin
        rs1Val  = regFile[issueInsn.immForm.rs1];
        rs2Val  = regFile[issueInsn.regForm.rs2];
        rdVal   = regFile[issueInsn.immForm.rd];
        immSext = {{8{issueInsn.immForm.imm[7]}}, issueInsn.immForm.imm};
        immZext = {8'b0, issueInsn.immForm.imm};

        kind     = MEM_NONE;
        writeReg = 1'b0;
        halt     = 1'b0;
        result   = '0;
        nextPc   = issuePc + 16'd1;

        case (issueInsn.immForm.opcode)
            LI: begin
                result   = immZext;
                writeReg = 1'b1;
            end
            ADDI: begin
                result   = rs1Val + immSext;
                writeReg = 1'b1;
            end
            ADD: begin
                result   = rs1Val + rs2Val;
                writeReg = 1'b1;
            end
            SUB: begin
                result   = rs1Val - rs2Val;
                writeReg = 1'b1;
            end
            XOR: begin
                result   = rs1Val ^ rs2Val;
                writeReg = 1'b1;
            end
            LD: begin
                kind     = MEM_LOAD;
                writeReg = 1'b1;
            end
            ST: kind = MEM_STORE;
            BEQZ: if (rs1Val == '0) nextPc = issuePc + 16'd1 + immSext;
            HALT: halt = 1'b1;
            default: ;  // Unknown opcodes retire as no-ops
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            em.valid <= 1'b0;
        end else begin
            em.valid <= issueValid;
        end
    end

    // Held until the next issue, so the memory stage can read it while waiting
    always_ff @(posedge clk) begin
        if (issueValid) begin
            em.kind      <= kind;
            em.addr      <= rs1Val + immSext;
            em.storeData <= rdVal;
            em.rd        <= issueInsn.immForm.rd;
            em.writeReg  <= writeReg;
            em.result    <= result;
            em.pc        <= issuePc;
            em.nextPc    <= nextPc;
            em.halt      <= halt;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            regFile <= '0;
        end else if (em.wbEn) begin
            regFile[em.wbReg] <= em.wbData;
        end
    end

endmodule : ExecuteStage

//--- rtl/FetchStage.sv
// Fetch stage
// PC and halt flag, one instruction fetch per retired instruction

module FetchStage #(
    parameter CorePkg::AddrPath ResetPc = '0
) (
    input  logic                clk,
    input  logic                reset,
    MemPortIF.fetch             mem,
    output logic                issueValid,
    output CorePkg::Instruction issueInsn,
    output CorePkg::AddrPath    issuePc,
    input  logic                retire,
    input  CorePkg::AddrPath    retireNextPc,
    input  logic                retireHalt
);
    import CorePkg::*;

    AddrPath pc;
    logic    fetchReq;
    logic    inFlight;
    logic    halted;

    assign mem.fetchReq  = fetchReq;
    assign mem.fetchAddr = pc;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc         <= ResetPc;
            fetchReq   <= 1'b0;
            inFlight   <= 1'b0;
            halted     <= 1'b0;
            issueValid <= 1'b0;
        end else begin
            issueValid <= 1'b0;
            if (mem.fetchValid) begin
                fetchReq   <= 1'b0;
                inFlight   <= 1'b1;
                issueValid <= 1'b1;
            end else if (retire) begin
                inFlight <= 1'b0;
                halted   <= retireHalt;
                fetchReq <= !retireHalt;
                if (!retireHalt) pc <= retireNextPc;
            end else if (!inFlight && !halted && !fetchReq) begin
                // First request out of reset
                fetchReq <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (mem.fetchValid) begin
            issueInsn <= mem.fetchData;
            issuePc   <= pc;
        end
    end

endmodule : FetchStage

//--- rtl/MemoryAccessController.sv
// External memory access controller
// Picks fetch or data requester, waits out the busy inputs,
// issues the access and matches the read response by serial

module MemoryAccessController (
    input  logic              clk,
    input  logic              reset,
    MemPortIF.ctrl            port,
    input  CorePkg::MemSerial nextMemReadSerial,
    input  CorePkg::MemSerial memReadSerial,
    input  CorePkg::DataPath  memReadData,
    input  logic              memReadDataReady,
    input  logic              memAccessReadBusy,
    input  logic              memAccessWriteBusy,
    output CorePkg::AddrPath  memAccessAddr,
    output CorePkg::DataPath  memAccessWriteData,
    output logic              memAccessRE,
    output logic              memAccessWE
);
    import CorePkg::*;

    typedef enum logic [1:0] {
        IDLE,
        ISSUE,
        WAIT_READ
    } State;

    State     state;
    logic     forData;
    logic     isWrite;
    AddrPath  addr;
    DataPath  wData;
    MemSerial pendingSerial;
    logic     readMatch;

    assign memAccessAddr      = addr;
    assign memAccessWriteData = wData;

    // Strobes only go out in a cycle where memory is not busy
    assign memAccessRE = (state == ISSUE) && !isWrite && !memAccessReadBusy;
    assign memAccessWE = (state == ISSUE) && isWrite && !memAccessWriteBusy;

    // Responses carrying a foreign serial are dropped
    assign readMatch = (state == WAIT_READ) && memReadDataReady &&
                       (memReadSerial == pendingSerial);

    assign port.fetchValid = readMatch && !forData;
    assign port.fetchData  = memReadData;
    assign port.dataDone   = forData && (readMatch || memAccessWE);
    assign port.dataRData  = memReadData;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: if (port.dataReq || port.fetchReq) state <= ISSUE;
                ISSUE: begin
                    if (memAccessWE) state <= IDLE;
                    else if (memAccessRE) state <= WAIT_READ;
                end
                WAIT_READ: if (readMatch) state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    // Data side wins when both are pending
    always_ff @(posedge clk) begin
        if (state == IDLE) begin
            forData <= port.dataReq;
            isWrite <= port.dataReq && port.dataWrite;
            addr    <= port.dataReq ? port.dataAddr : port.fetchAddr;
            wData   <= port.dataWData;
        end
        if (memAccessRE) pendingSerial <= nextMemReadSerial;
    end

endmodule : MemoryAccessController

//--- rtl/CoreIF.sv
// Interfaces between the core stages
// MemPortIF joins fetch and memory stage to the access controller
// ExecMemIF carries an executed instruction to the memory stage

interface MemPortIF;
    import CorePkg::*;

    // Instruction side
    logic    fetchReq;
    AddrPath fetchAddr;
    logic    fetchValid;
    DataPath fetchData;

    // Data side
    logic    dataReq;
    logic    dataWrite;
    AddrPath dataAddr;
    DataPath dataWData;
    logic    dataDone;
    DataPath dataRData;

    modport fetch (
        output fetchReq, fetchAddr,
        input  fetchValid, fetchData
    );

    modport data (
        output dataReq, dataWrite, dataAddr, dataWData,
        input  dataDone, dataRData
    );

    modport ctrl (
        input  fetchReq, fetchAddr, dataReq, dataWrite, dataAddr, dataWData,
        output fetchValid, fetchData, dataDone, dataRData
    );
endinterface : MemPortIF

interface ExecMemIF;
    import CorePkg::*;

    logic    valid;
    MemKind  kind;
    AddrPath addr;
    DataPath storeData;
    RegNum   rd;
    logic    writeReg;
    DataPath result;
    AddrPath pc;
    AddrPath nextPc;
    logic    halt;

    // Register file write port, driven back by the memory stage
    logic    wbEn;
    RegNum   wbReg;
    DataPath wbData;

    modport exec (
        output valid, kind, addr, storeData, rd, writeReg, result, pc, nextPc, halt,
        input  wbEn, wbReg, wbData
    );

    modport mem (
        input  valid, kind, addr, storeData, rd, writeReg, result, pc, nextPc, halt,
        output wbEn, wbReg, wbData
    );
endinterface : ExecMemIF

//--- rtl/CorePkg.sv
// Shared types of the core
// Data and address widths, opcodes, the two instruction
// encodings with their union, and the memory access kind

package CorePkg;

    // Machine word and word address
    typedef logic [15:0] DataPath;
    typedef logic [15:0] AddrPath;

    // Four architectural registers
    typedef logic [1:0] RegNum;

    // Serial tag of an external read
    typedef logic [3:0] MemSerial;

    typedef enum logic [3:0] {
        LI   = 4'd0,
        ADDI = 4'd1,
        ADD  = 4'd2,
        SUB  = 4'd3,
        XOR  = 4'd4,
        LD   = 4'd5,
        ST   = 4'd6,
        BEQZ = 4'd7,
        HALT = 4'd15
    } Opcode;

    // Three-register ALU operations
    typedef struct packed {
        Opcode      opcode;
        RegNum      rd;
        RegNum      rs1;
        RegNum      rs2;
        logic [5:0] pad;
    } RegForm;

    // Immediate, memory and control operations
    typedef struct packed {
        Opcode      opcode;
        RegNum      rd;
        RegNum      rs1;
        logic [7:0] imm;
    } ImmForm;

    // Opcode, rd and rs1 sit at the same bits in both views
    typedef union packed {
        RegForm regForm;
        ImmForm immForm;
    } Instruction;

    typedef enum logic [1:0] {
        MEM_NONE  = 2'd0,
        MEM_LOAD  = 2'd1,
        MEM_STORE = 2'd2
    } MemKind;

endpackage : CorePkg
